// File: hdl/wb_pkg.sv
/*
  Shared types and constants for the write-back end of the pipeline.
  Every write-back module imports this package in its header.
*/

package wb_pkg;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  // Register index
  typedef logic [4:0] rf_addr_t;

  // x0 is hardwired to zero
  localparam rf_addr_t RF_ZERO = 5'd0;

  // Load access size
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Memory protection result, returned with the bus response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  localparam mpu_status_e MPU_OK_VAL = MPU_OK;

  // Offload transaction ID
  typedef logic [3:0] xif_id_t;

  ////////////////////////////////////////
  // Pipeline and port structs
  ////////////////////////////////////////

  // Instruction held in write-back
  typedef struct packed {
    logic            instr_valid;
    logic            rf_we;
    rf_addr_t        rf_waddr;
    logic [XLEN-1:0] rf_wdata;
    logic            lsu_en;
    lsu_size_e       lsu_size;
    logic            lsu_signed;
    logic [1:0]      lsu_offset;
    logic            xif_en;
    xif_id_t         xif_id;
    logic            dummy;
  } ex_wb_pipe_t;

  // Controller requests toward write-back
  typedef struct packed {
    logic kill_wb;
    logic halt_wb;
  } ctrl_fsm_t;

  // Bus data word, seen either whole or as four byte lanes
  typedef union packed {
    logic [XLEN-1:0] word;
    logic [3:0][7:0] bytes;
  } bus_word_u;

  // Data bus response
  typedef struct packed {
    bus_word_u   rdata;
    mpu_status_e mpu_status;
  } lsu_resp_t;

  // Coprocessor result
  typedef struct packed {
    xif_id_t         id;
    logic [XLEN-1:0] data;
    logic            we;
    logic            exc;
  } xif_result_t;

  // Register file write port
  typedef struct packed {
    logic            we;
    rf_addr_t        waddr;
    logic [XLEN-1:0] wdata;
  } rf_wr_t;

  // Retirement report
  typedef struct packed {
    logic valid;
    logic exception;
    logic data_stall;
  } wb_status_t;

endpackage

// File: hdl/ex_wb_pipe.sv
/*
  EX/WB pipeline register. Takes one instruction from execute over valid/ready
  and holds it until write-back reports completion or the controller kills it.
*/

`timescale 1ns/1ps

module ex_wb_pipe import wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_instr_i,
  output logic        ex_ready_o,
  input  logic        wb_done_i,
  input  ctrl_fsm_t   ctrl_i,
  output ex_wb_pipe_t wb_instr_o
);

  logic        valid_q;
  ex_wb_pipe_t instr_q;

  // A kill takes effect at once, so nothing downstream sees the instruction
  always_comb begin
    wb_instr_o             = instr_q;
    wb_instr_o.instr_valid = valid_q && !ctrl_i.kill_wb;
  end

  // Free slot, or the current one leaves this cycle
  assign ex_ready_o = !wb_instr_o.instr_valid || wb_done_i;

  ////////////////////////////////////////
  // Occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ex_valid_i && ex_ready_o) begin
      valid_q <= ex_instr_i.instr_valid;
    end else if (wb_done_i || ctrl_i.kill_wb) begin
      valid_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (ex_valid_i && ex_ready_o) begin
      instr_q <= ex_instr_i;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Execute keeps its offer steady until the transfer
  a_ex_instr_stable : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (ex_valid_i && !ex_ready_o) |=> (ex_valid_i && $stable(ex_instr_i))
  ) else $error("ex_instr_i changed while waiting for ex_ready_o");

endmodule

// File: hdl/lsu_resp_unit.sv
/*
  Load response unit. Picks the addressed lane out of the bus word, extends it
  to XLEN and reports protection faults, which also finish the load.
*/

`timescale 1ns/1ps

module lsu_resp_unit import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_wb_pipe_t     wb_instr_i,
  input  logic            resp_valid_i,
  input  lsu_resp_t       resp_i,
  output logic            resp_ready_o,
  output logic [XLEN-1:0] load_data_o,
  output logic            load_done_o,
  output logic            load_fault_o
);

  logic       load_active;
  logic       handshake;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;
  logic       sign_bit;

  // Load sitting in write-back
  assign load_active  = wb_instr_i.instr_valid && wb_instr_i.lsu_en;
  assign resp_ready_o = load_active;
  assign handshake    = load_active && resp_valid_i;

  // Protection status only counts with a valid response
  assign load_fault_o = handshake && (resp_i.mpu_status != MPU_OK_VAL);
  // Any response ends the load, a faulting one included
  assign load_done_o  = handshake;

  ////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////

  // Byte lane straight from the offset
  assign byte_sel = resp_i.rdata.bytes[wb_instr_i.lsu_offset];

  // Halfword lane from the upper offset bit
  assign half_sel = {resp_i.rdata.bytes[{wb_instr_i.lsu_offset[1], 1'b1}],
                     resp_i.rdata.bytes[{wb_instr_i.lsu_offset[1], 1'b0}]};

  always_comb begin
    sign_bit    = 1'b0;
    load_data_o = resp_i.rdata.word;
    case (wb_instr_i.lsu_size)
      LSU_BYTE: begin
        sign_bit    = wb_instr_i.lsu_signed && byte_sel[7];
        load_data_o = {{(XLEN-8){sign_bit}}, byte_sel};
      end
      LSU_HALF: begin
        sign_bit    = wb_instr_i.lsu_signed && half_sel[15];
        load_data_o = {{(XLEN-16){sign_bit}}, half_sel};
      end
      default: begin
        // Full word needs no alignment
        load_data_o = resp_i.rdata.word;
      end
    endcase
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // The bus only answers a load that is waiting in write-back
  a_no_stray_resp : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    resp_valid_i |-> load_active
  ) else $error("Load response without a load in write-back");

endmodule

// File: hdl/xif_result_unit.sv
/*
  Coprocessor result unit. Takes the offloaded result while the offloaded
  instruction is in write-back and flags results that must not be written.
*/

`timescale 1ns/1ps

module xif_result_unit import wb_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  ex_wb_pipe_t     wb_instr_i,
  input  logic            result_valid_i,
  input  xif_result_t     result_i,
  output logic            result_ready_o,
  output logic [XLEN-1:0] xif_data_o,
  output logic            xif_done_o,
  output logic            xif_exc_o
);

  logic xif_active;
  logic handshake;
  logic id_match;

  // Ready as soon as the offloaded instruction reaches write-back
  assign xif_active     = wb_instr_i.instr_valid && wb_instr_i.xif_en;
  assign result_ready_o = xif_active;
  assign handshake      = xif_active && result_valid_i;

  // Result must belong to the instruction in write-back
  assign id_match = (result_i.id == wb_instr_i.xif_id);

  assign xif_data_o = result_i.data;
  assign xif_done_o = handshake;

  // Exception, foreign ID or no write request all block the register write
  assign xif_exc_o = handshake && (result_i.exc || !id_match || !result_i.we);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Coprocessor and pipeline agree on the transaction ID
  a_xif_id_match : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    handshake |-> id_match
  ) else $error("Coprocessor result ID does not match instruction in write-back");

endmodule

// File: hdl/wb_stage.sv
/*
  Write-back stage. Merges the pipe register result with the load and
  coprocessor results into the register write, retirement and load stall.
*/

`timescale 1ns/1ps

module wb_stage import wb_pkg::*; (
  input  ex_wb_pipe_t     wb_instr_i,
  input  ctrl_fsm_t       ctrl_i,
  input  logic [XLEN-1:0] load_data_i,
  input  logic            load_done_i,
  input  logic            load_fault_i,
  input  logic [XLEN-1:0] xif_data_i,
  input  logic            xif_done_i,
  input  logic            xif_exc_i,
  output logic            wb_done_o,
  output rf_wr_t          rf_wr_o,
  output wb_status_t      status_o
);

  logic instr_active;
  logic completed;
  logic retire;
  logic exception;
  logic block_r0_we;

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////

  // Kill is already folded into instr_valid by the pipe register
  assign instr_active = wb_instr_i.instr_valid && !ctrl_i.halt_wb;

  // Loads and offloads wait for their unit, others finish right away
  always_comb begin
    if (wb_instr_i.lsu_en) begin
      completed = load_done_i;
    end else if (wb_instr_i.xif_en) begin
      completed = xif_done_i;
    end else begin
      completed = 1'b1;
    end
  end

  assign retire    = instr_active && completed;
  assign exception = load_fault_i || xif_exc_i;
  assign wb_done_o = retire;

  ////////////////////////////////////////
  // Register file write
  ////////////////////////////////////////

  // x0 writes only go through for dummy instructions
  assign block_r0_we = (wb_instr_i.rf_waddr == RF_ZERO) && !wb_instr_i.dummy;

  assign rf_wr_o.we    = wb_instr_i.rf_we && retire && !exception && !block_r0_we;
  assign rf_wr_o.waddr = wb_instr_i.rf_waddr;

  // Load data first, then coprocessor data, then the EX result
  always_comb begin
    if (wb_instr_i.lsu_en) begin
      rf_wr_o.wdata = load_data_i;
    end else if (wb_instr_i.xif_en) begin
      rf_wr_o.wdata = xif_data_i;
    end else begin
      rf_wr_o.wdata = wb_instr_i.rf_wdata;
    end
  end

  ////////////////////////////////////////
  // Retirement report
  ////////////////////////////////////////

  assign status_o.valid      = retire;
  assign status_o.exception  = retire && exception;
  // Load stuck waiting on the bus
  assign status_o.data_stall = instr_active && wb_instr_i.lsu_en && !load_done_i;

endmodule

// File: hdl/wb_top.sv
/*
  Write-back subsystem top. Connects the EX/WB register, both result units
  and the write-back stage; holds no logic of its own.
*/

`timescale 1ns/1ps

module wb_top import wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  // Execute stage
  input  logic        ex_valid_i,
  input  ex_wb_pipe_t ex_instr_i,
  output logic        ex_ready_o,
  // Data bus response
  input  logic        lsu_resp_valid_i,
  input  lsu_resp_t   lsu_resp_i,
  output logic        lsu_resp_ready_o,
  // Coprocessor result
  input  logic        xif_valid_i,
  input  xif_result_t xif_result_i,
  output logic        xif_ready_o,
  // Controller
  input  ctrl_fsm_t   ctrl_i,
  // Register file and retirement
  output rf_wr_t      rf_wr_o,
  output wb_status_t  status_o
);

  ex_wb_pipe_t     wb_instr;
  logic            wb_done;
  logic [XLEN-1:0] load_data;
  logic            load_done;
  logic            load_fault;
  logic [XLEN-1:0] xif_data;
  logic            xif_done;
  logic            xif_exc;

  ex_wb_pipe u_ex_wb_pipe (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ex_valid_i (ex_valid_i),
    .ex_instr_i (ex_instr_i),
    .ex_ready_o (ex_ready_o),
    .wb_done_i  (wb_done),
    .ctrl_i     (ctrl_i),
    .wb_instr_o (wb_instr)
  );

  lsu_resp_unit u_lsu_resp_unit (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .wb_instr_i   (wb_instr),
    .resp_valid_i (lsu_resp_valid_i),
    .resp_i       (lsu_resp_i),
    .resp_ready_o (lsu_resp_ready_o),
    .load_data_o  (load_data),
    .load_done_o  (load_done),
    .load_fault_o (load_fault)
  );

  xif_result_unit u_xif_result_unit (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .wb_instr_i     (wb_instr),
    .result_valid_i (xif_valid_i),
    .result_i       (xif_result_i),
    .result_ready_o (xif_ready_o),
    .xif_data_o     (xif_data),
    .xif_done_o     (xif_done),
    .xif_exc_o      (xif_exc)
  );

  wb_stage u_wb_stage (
    .wb_instr_i   (wb_instr),
    .ctrl_i       (ctrl_i),
    .load_data_i  (load_data),
    .load_done_i  (load_done),
    .load_fault_i (load_fault),
    .xif_data_i   (xif_data),
    .xif_done_i   (xif_done),
    .xif_exc_i    (xif_exc),
    .wb_done_o    (wb_done),
    .rf_wr_o      (rf_wr_o),
    .status_o     (status_o)
  );

endmodule

// File: dv/tb_wb_top.sv
/*
  Testbench for the write-back subsystem. Reads one instruction per line from
  the cases file, drives execute, bus and coprocessor sides with random response
  delays and checks register write, retirement and ready signals every cycle.
*/

`timescale 1ns/1ps

module tb_wb_top import wb_pkg::*; ();

  localparam int NCASE          = 22;
  localparam int NCOL           = 13;
  localparam int HALT_CYCLES    = 2;
  localparam int TIMEOUT_CYCLES = 8 * NCASE + 20;

  logic        clk;
  logic        rst_n_i;
  logic        ex_valid_i;
  ex_wb_pipe_t ex_instr_i;
  logic        ex_ready_o;
  logic        lsu_resp_valid_i;
  lsu_resp_t   lsu_resp_i;
  logic        lsu_resp_ready_o;
  logic        xif_valid_i;
  xif_result_t xif_result_i;
  logic        xif_ready_o;
  ctrl_fsm_t   ctrl_i;
  rf_wr_t      rf_wr_o;
  wb_status_t  status_o;

  // Flat image of the cases file with NCOL words per case
  logic [31:0] cases_mem [NCASE*NCOL];
  logic [31:0] in_row [NCOL];
  logic [31:0] wb_row [NCOL];
  int          delay_q [NCASE];
  int          seed;
  int          cycle_cnt = 0;
  int          issue;
  // Case in write-back, cycles spent there, end of halt, expected retire cycle
  int          wb_idx;
  int          wb_cyc;
  int          wb_start;
  int          wb_ret;
  logic        done;

  wb_top UUT (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Cycle budget for the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: DUT did not retire all cases within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "Run stopped by timeout");
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "Mismatch against expected value");
  endtask

  // Address and data only matter when a write is expected
  task automatic check_rf_wr(input rf_wr_t act, input rf_wr_t exp, input int idx);
    if (act.we !== exp.we || (exp.we && (act.waddr !== exp.waddr || act.wdata !== exp.wdata)))
      report_mismatch($sformatf("case %0d rf_wr we=%0b x%0d=%h, expected we=%0b x%0d=%h",
                                idx, act.we, act.waddr, act.wdata, exp.we, exp.waddr, exp.wdata));
  endtask

  task automatic check_status(input wb_status_t act, input wb_status_t exp, input int idx);
    if (act !== exp)
      report_mismatch($sformatf("case %0d status valid/exc/stall=%b, expected %b",
                                idx, act, exp));
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what, input int idx);
    if (act !== exp)
      report_mismatch($sformatf("case %0d %s=%0b, expected %0b", idx, what, act, exp));
  endtask

  ////////////////////////////////////////
  // Stimulus and expected values
  ////////////////////////////////////////

  function automatic ex_wb_pipe_t build_instr(input int idx);
    ex_wb_pipe_t instr;
    instr             = '0;
    instr.instr_valid = 1'b1;
    instr.rf_we       = 1'b1;
    instr.rf_waddr    = in_row[2][4:0];
    instr.rf_wdata    = in_row[3];
    instr.lsu_en      = (in_row[0][1:0] == 2'd1);
    instr.lsu_size    = lsu_size_e'(in_row[4][1:0]);
    instr.lsu_signed  = in_row[5][0];
    instr.lsu_offset  = in_row[6][1:0];
    instr.xif_en      = (in_row[0][1:0] == 2'd2);
    instr.xif_id      = idx[3:0];
    instr.dummy       = in_row[7][0];
    return instr;
  endfunction

  // Controller, bus and coprocessor inputs for the case in write-back
  task automatic drive_wb_side();
    logic answer;
    ctrl_i           = '0;
    lsu_resp_valid_i = 1'b0;
    lsu_resp_i       = '0;
    xif_valid_i      = 1'b0;
    xif_result_i     = '0;
    if (wb_idx >= 0) begin
      ctrl_i.kill_wb = (wb_row[1][1:0] == 2'd1);
      ctrl_i.halt_wb = (wb_row[1][1:0] == 2'd2) && (wb_cyc < wb_start);
      answer         = (wb_row[1][1:0] != 2'd1) && (wb_cyc >= wb_ret);
      // Payload is already on the bus while valid is still low
      if (wb_row[0][1:0] == 2'd1) begin
        lsu_resp_valid_i      = answer;
        lsu_resp_i.rdata.word = wb_row[8];
        lsu_resp_i.mpu_status = mpu_status_e'(wb_row[9][1:0]);
      end else if (wb_row[0][1:0] == 2'd2) begin
        xif_valid_i       = answer;
        xif_result_i.id   = wb_idx[3:0];
        xif_result_i.data = wb_row[8];
        xif_result_i.we   = wb_row[9][1];
        xif_result_i.exc  = wb_row[9][0];
      end
    end
  endtask

  // Kind 3 stands for an empty write-back slot
  task automatic check_cycle(output logic retired);
    logic       kill;
    logic       ret;
    logic [1:0] kind;
    rf_wr_t     exp_wr;
    wb_status_t exp_st;
    kind                = (wb_idx >= 0) ? wb_row[0][1:0] : 2'd3;
    kill                = (wb_idx >= 0) && (wb_row[1][1:0] == 2'd1);
    ret                 = (wb_idx >= 0) && !kill && (wb_cyc == wb_ret);
    exp_wr.we           = ret && wb_row[10][0];
    exp_wr.waddr        = wb_row[2][4:0];
    exp_wr.wdata        = wb_row[11];
    exp_st.valid        = ret;
    exp_st.exception    = ret && wb_row[12][0];
    exp_st.data_stall   = (kind == 2'd1) && !kill && !ret && (wb_cyc >= wb_start);
    check_rf_wr(rf_wr_o, exp_wr, wb_idx);
    check_status(status_o, exp_st, wb_idx);
    check_flag(ex_ready_o, (wb_idx < 0) || kill || ret, "ex_ready_o", wb_idx);
    check_flag(lsu_resp_ready_o, (kind == 2'd1) && !kill, "lsu_resp_ready_o", wb_idx);
    check_flag(xif_ready_o, (kind == 2'd2) && !kill, "xif_ready_o", wb_idx);
    retired = kill || ret;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n_i    = 1'b0;
    ex_valid_i = 1'b0;
    ex_instr_i = '0;
    wb_idx     = -1;
    wb_cyc     = 0;
    drive_wb_side();
    $readmemh("dv/wb_cases.txt", cases_mem);
    seed = 19;
    for (int i = 0; i < NCASE; i++) delay_q[i] = $unsigned($random(seed)) % 4;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;
    issue   = 0;
    while (issue < NCASE || wb_idx >= 0) begin
      // Offer the next case and answer the one in write-back on the falling edge
      if (issue < NCASE)
        for (int c = 0; c < NCOL; c++) in_row[c] = cases_mem[issue*NCOL + c];
      ex_valid_i = (issue < NCASE);
      ex_instr_i = (issue < NCASE) ? build_instr(issue) : '0;
      drive_wb_side();
      // Outputs seen at the rising edge still belong to the low phase
      @(posedge clk);
      check_cycle(done);
      if (ex_valid_i && ex_ready_o) begin
        wb_row   = in_row;
        wb_idx   = issue;
        wb_start = (in_row[1][1:0] == 2'd2) ? HALT_CYCLES : 0;
        wb_ret   = wb_start + ((in_row[0][1:0] == 2'd0) ? 0 : delay_q[issue]);
        wb_cyc   = 0;
        issue++;
      end else if (done) begin
        wb_idx = -1;
      end else begin
        wb_cyc++;
      end
      @(negedge clk);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: dv/wb_cases.txt
// kind ctrl waddr wdata size sgn off dummy rdata flags  then expected: we wdata exc
// kind 0 alu 1 load 2 xif, ctrl 1 kill 2 halt, flags mpu status or {we,exc}
0 0 01 12345678 0 0 0 0 00000000 0 1 12345678 0
0 0 02 deadbeef 0 0 0 0 00000000 0 1 deadbeef 0
0 0 03 00000042 0 0 0 0 00000000 0 1 00000042 0
1 0 04 00000000 0 0 0 0 f18273a4 0 1 000000a4 0
1 0 05 00000000 0 1 0 0 f18273a4 0 1 ffffffa4 0
1 0 06 00000000 0 1 1 0 f18273a4 0 1 00000073 0
1 0 07 00000000 0 0 2 0 f18273a4 0 1 00000082 0
1 0 08 00000000 0 1 3 0 f18273a4 0 1 fffffff1 0
1 0 09 00000000 1 0 0 0 f18273a4 0 1 000073a4 0
1 0 0a 00000000 1 1 2 0 f18273a4 0 1 fffff182 0
1 0 0b 00000000 1 0 2 0 f18273a4 0 1 0000f182 0
1 0 0c 00000000 2 0 0 0 f18273a4 0 1 f18273a4 0
1 0 0d 00000000 0 0 1 0 f18273a4 1 0 00000000 1
1 0 0e 00000000 2 1 0 0 5a5a5a5a 2 0 00000000 1
2 0 0f 00000000 0 0 0 0 cafef00d 2 1 cafef00d 0
2 0 10 00000000 0 0 0 0 0badc0de 3 0 00000000 1
2 0 11 00000000 0 0 0 0 13579bdf 0 0 00000000 1
0 0 00 11111111 0 0 0 0 00000000 0 0 00000000 0
0 0 00 22222222 0 0 0 1 00000000 0 1 22222222 0
0 1 12 33333333 0 0 0 0 00000000 0 0 00000000 0
0 2 13 44444444 0 0 0 0 00000000 0 1 44444444 0
1 0 14 00000000 0 1 3 0 807f6e5d 0 1 ffffff80 0

// File: files.f
hdl/wb_pkg.sv
hdl/ex_wb_pipe.sv
hdl/lsu_resp_unit.sv
hdl/xif_result_unit.sv
hdl/wb_stage.sv
hdl/wb_top.sv
dv/tb_wb_top.sv

// File: Makefile
# Verilator build and run of the write-back testbench

SIM := obj_dir/Vtb_wb_top

$(SIM): files.f $(wildcard hdl/*.sv dv/*.sv)
	verilator --binary --timing --assert --top-module tb_wb_top -Mdir obj_dir -f files.f

.PHONY: run clean

# Pass only when the testbench prints its pass line
run: $(SIM) dv/wb_cases.txt
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
